//--- icache.f
logic/icache_pkg.sv
logic/icache_tag_array.sv
logic/icache_data_array.sv
logic/icache_lru.sv
logic/icache_maint_regs.sv
logic/icache_ctrl.sv
logic/icache_top.sv
sim/icache_properties.sv
sim/icache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the icache testbench with Verilator and runs it; exit status gives the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module icache_tb -f icache.f -o icache_sim \
    && ./obj_dir/icache_sim \
    || { echo "icache simulation build or run failed"; exit 1; }

//--- sim/icache_tb.sv
// icache testbench with clock, reset, random fetches, memory responder, reference model, checks
`timescale 1ns/1ns
`default_nettype none

module icache_tb import icache_pkg::*; ();

    localparam logic [31:0] SEED          = 32'h80a9_f5a4;
    localparam addr_t       WIN_BASE      = 32'h0001_0000;
    localparam int          RSP_TIMEOUT   = 64;
    localparam int          IDLE_TIMEOUT  = 64;
    localparam int          SWEEP_TIMEOUT = 64;

    logic             clk = 1'b0;
    logic             rst_n;
    logic             fetch_req_valid;
    fetch_req_t       fetch_req;
    logic             fetch_rsp_valid;
    fetch_rsp_t       fetch_rsp;
    logic             busy;
    logic             mem_req_valid;
    mem_req_t         mem_req;
    logic             mem_rsp_valid;
    line_t            mem_rsp_data;
    logic             cfg_we;
    logic [CFG_W-1:0] cfg_wdata;

    // reference model state
    tag_t        m_tag [2][NUM_SETS];
    logic        m_valid [2][NUM_SETS];
    logic        m_lru [NUM_SETS];
    logic        m_enable;
    logic [15:0] epoch;
    addr_t       resident [$];
    int          n_fetch;
    int          n_hit;

    always #2 clk = ~clk;

    icache_top u_icache_top (
        .clk             (clk),
        .rst_n           (rst_n),
        .fetch_req_valid (fetch_req_valid),
        .fetch_req       (fetch_req),
        .fetch_rsp_valid (fetch_rsp_valid),
        .fetch_rsp       (fetch_rsp),
        .busy            (busy),
        .mem_req_valid   (mem_req_valid),
        .mem_req         (mem_req),
        .mem_rsp_valid   (mem_rsp_valid),
        .mem_rsp_data    (mem_rsp_data),
        .cfg_we          (cfg_we),
        .cfg_wdata       (cfg_wdata)
    );

    bind icache_top icache_properties u_icache_properties (
        .clk             (clk),
        .rst_n           (rst_n),
        .fetch_req_valid (fetch_req_valid),
        .busy            (busy),
        .fetch_rsp_valid (fetch_rsp_valid),
        .mem_req_valid   (mem_req_valid)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_rsp(input fetch_rsp_t got, input fetch_rsp_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail fetch_rsp: got %h/%h/%h, expected %h/%h/%h",
                got.data, got.pc, got.second_valid, exp.data, exp.pc, exp.second_valid));
        end
    endtask

    task automatic check_mem_req(input mem_req_t got, input mem_req_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail mem_req.addr: got %h, expected %h", got.addr, exp.addr));
        end
    endtask

    // a failed bound assertion ends the run at the next edge
    always @(posedge clk) begin
        if (u_icache_top.u_icache_properties.assert_failed) begin
            abort_run("a bound assertion on the cache ports failed");
        end
    end

    //////////////////////////////
    // memory contents and model
    //////////////////////////////
    // word value depends on the word address and the epoch
    function automatic word_t mem_word(addr_t byte_addr);
        return ({2'b00, byte_addr[31:2]} * 32'h9e37_79b1) ^ {epoch, ~epoch};
    endfunction

    // returns the predicted hit and applies fill and LRU update
    function automatic logic model_access(addr_t pc);
        index_t idx;
        tag_t   tg;
        logic   way;
        idx = pc[7:4];
        tg  = pc[31:6];
        if (!m_enable) begin
            return 1'b0;
        end
        for (int w = 0; w < 2; w++) begin
            if (m_valid[w][idx] && (m_tag[w][idx] == tg)) begin
                m_lru[idx] = (w == 0);
                return 1'b1;
            end
        end
        if (!m_valid[0][idx]) begin
            way = 1'b0;
        end else if (!m_valid[1][idx]) begin
            way = 1'b1;
        end else begin
            way = m_lru[idx];
        end
        m_tag[way][idx]   = tg;
        m_valid[way][idx] = 1'b1;
        m_lru[idx]        = ~way;
        return 1'b0;
    endfunction

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy) begin
            @(posedge clk);
            n++;
            if (n > IDLE_TIMEOUT) begin
                abort_run("timeout waiting for busy to fall");
            end
        end
    endtask

    //////////////////////////////
    // fetch with memory responder
    //////////////////////////////
    task automatic do_fetch(input addr_t pc);
        logic       exp_hit;
        line_t      line;
        word_t      words [4];
        offset_t    off;
        fetch_rsp_t exp_rsp;
        mem_req_t   exp_req;
        int         n;
        int         mem_at;
        int         rsp_edge;
        int         rsp_at;
        exp_hit = model_access(pc);
        exp_req = '{addr: {pc[31:4], 4'h0}};
        for (int i = 0; i < 4; i++) begin
            words[i]          = mem_word(exp_req.addr + addr_t'(4 * i));
            line[32*i +: 32]  = words[i];
        end
        off                  = pc[3:2];
        exp_rsp.pc           = pc;
        exp_rsp.second_valid = ~off[0];
        exp_rsp.data = off[0] ? {32'h0, words[off]} : {words[off + 2'd1], words[off]};

        wait_idle();
        fetch_req_valid <= 1'b1;
        fetch_req       <= '{pc: pc};
        @(posedge clk);
        fetch_req_valid <= 1'b0;
        n        = 1;
        mem_at   = -1;
        rsp_edge = -1;
        rsp_at   = -1;
        while (rsp_at < 0) begin
            @(posedge clk);
            n++;
            mem_rsp_valid <= 1'b0;
            if (fetch_rsp_valid) begin
                rsp_at = n;
                check_rsp(fetch_rsp, exp_rsp);
            end else if (!busy) begin
                abort_run("busy was low while a fetch was still in flight");
            end
            if (mem_req_valid) begin
                if (exp_hit || (mem_at >= 0)) begin
                    abort_run("memory request seen for a predicted hit or a second time");
                end
                if (n != 3) begin
                    abort_run("memory request did not come 2 cycles after the fetch strobe");
                end
                check_mem_req(mem_req, exp_req);
                mem_at   = n;
                // answer 1 to 8 cycles later
                rsp_edge = n + int'($urandom % 8);
            end
            if (n == rsp_edge) begin
                mem_rsp_valid <= 1'b1;
                mem_rsp_data  <= line;
            end
            if (n > RSP_TIMEOUT) begin
                abort_run("timeout waiting for the fetch response");
            end
        end
        if (exp_hit && (rsp_at != 3)) begin
            abort_run("hit response did not come 2 cycles after the fetch strobe");
        end
        if (!exp_hit && ((mem_at < 0) || (rsp_at != rsp_edge + 2))) begin
            abort_run("miss response did not follow the memory response by 1 cycle");
        end
        n_fetch++;
        if (exp_hit) begin
            n_hit++;
        end
    endtask

    task automatic random_fetch();
        logic [31:0] line_no;
        logic [31:0] word_no;
        line_no = $urandom % 48;
        word_no = $urandom % 4;
        do_fetch(WIN_BASE + (line_no * 16) + (word_no * 4));
    endtask

    task automatic write_cfg(input logic [CFG_W-1:0] value);
        cfg_we    <= 1'b1;
        cfg_wdata <= value;
        @(posedge clk);
        cfg_we    <= 1'b0;
        m_enable   = value[0];
    endtask

    task automatic collect_resident();
        index_t idx;
        addr_t  pc;
        resident.delete();
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < 2; w++) begin
                if (m_valid[w][s]) begin
                    idx      = index_t'(s);
                    pc       = {m_tag[w][s], idx[1:0], 4'h0};
                    pc[3:2]  = 2'($urandom % 4);
                    resident.push_back(pc);
                end
            end
        end
    endtask

    task automatic invalidate_all();
        int high;
        epoch = epoch + 16'd1;
        write_cfg(2'b11);
        @(posedge clk);
        if (!busy) begin
            abort_run("busy did not rise after the invalidate write");
        end
        high = 0;
        while (busy) begin
            high++;
            if (high > SWEEP_TIMEOUT) begin
                abort_run("timeout waiting for the invalidate sweep to end");
            end
            @(posedge clk);
        end
        if (high < NUM_SETS) begin
            abort_run("busy fell before the sweep covered every set");
        end
        for (int s = 0; s < NUM_SETS; s++) begin
            m_valid[0][s] = 1'b0;
            m_valid[1][s] = 1'b0;
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n           = 1'b0;
        fetch_req_valid = 1'b0;
        fetch_req       = '0;
        mem_rsp_valid   = 1'b0;
        mem_rsp_data    = '0;
        cfg_we          = 1'b0;
        cfg_wdata       = '0;
        m_enable        = 1'b1;
        epoch           = '0;
        n_fetch         = 0;
        n_hit           = 0;
        for (int s = 0; s < NUM_SETS; s++) begin
            m_valid[0][s] = 1'b0;
            m_valid[1][s] = 1'b0;
            m_lru[s]      = 1'b0;
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        repeat (400) random_fetch();

        // three lines of set 5 fighting over two ways
        do_fetch(WIN_BASE + 32'h050);
        do_fetch(WIN_BASE + 32'h154);
        do_fetch(WIN_BASE + 32'h058);
        do_fetch(WIN_BASE + 32'h25c);
        do_fetch(WIN_BASE + 32'h150);
        do_fetch(WIN_BASE + 32'h054);
        do_fetch(WIN_BASE + 32'h258);
        do_fetch(WIN_BASE + 32'h25c);

        // lines filled before the uncached window must still hit
        collect_resident();
        write_cfg(2'b00);
        repeat (40) random_fetch();
        write_cfg(2'b01);
        foreach (resident[i]) begin
            do_fetch(resident[i]);
        end

        // new epoch is only visible after the sweep
        collect_resident();
        invalidate_all();
        foreach (resident[i]) begin
            do_fetch(resident[i]);
        end
        repeat (200) random_fetch();

        $display("%0d fetches checked, %0d hits", n_fetch, n_hit);
        if (u_icache_top.u_icache_properties.assert_failed) begin
            abort_run("a bound assertion on the cache ports failed");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- sim/icache_properties.sv
// bound assertions on fetch handshake, reset values and single-cycle strobes
`timescale 1ns/1ns
`default_nettype none

module icache_properties (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic fetch_req_valid,
    input wire logic busy,
    input wire logic fetch_rsp_valid,
    input wire logic mem_req_valid
);

    logic assert_failed = 1'b0;

    //////////////////////////////
    // fetch handshake
    //////////////////////////////
    // requester only strobes while idle
    no_strobe_while_busy: assert property (
        @(posedge clk) disable iff (!rst_n) fetch_req_valid |-> !busy
    ) else begin
        $error("fetch strobe arrived while busy was high");
        assert_failed = 1'b1;
    end

    rsp_single_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) fetch_rsp_valid |=> !fetch_rsp_valid
    ) else begin
        $error("fetch_rsp_valid held high for more than one cycle");
        assert_failed = 1'b1;
    end

    mem_req_single_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) mem_req_valid |=> !mem_req_valid
    ) else begin
        $error("mem_req_valid held high for more than one cycle");
        assert_failed = 1'b1;
    end

    //////////////////////////////
    // reset
    //////////////////////////////
    outputs_low_in_reset: assert property (
        @(posedge clk) !rst_n |=> (!fetch_rsp_valid && !mem_req_valid && !busy)
    ) else begin
        $error("strobe or busy output high after a reset cycle");
        assert_failed = 1'b1;
    end

endmodule

`default_nettype wire

//--- logic/icache_top.sv
// icache top level, tag and data arrays, LRU, maintenance registers and controller
`timescale 1ns/1ns
`default_nettype none

module icache_top import icache_pkg::*; (
    input  wire logic             clk,
    input  wire logic             rst_n,
    // fetch port
    input  wire logic             fetch_req_valid,
    input  wire fetch_req_t       fetch_req,
    output logic                  fetch_rsp_valid,
    output fetch_rsp_t            fetch_rsp,
    output logic                  busy,
    // memory port
    output logic                  mem_req_valid,
    output mem_req_t              mem_req,
    input  wire logic             mem_rsp_valid,
    input  wire line_t            mem_rsp_data,
    // maintenance port
    input  wire logic             cfg_we,
    input  wire logic [CFG_W-1:0] cfg_wdata
);

    index_t              rd_index;
    tag_t                cmp_tag;
    logic [NUM_WAYS-1:0] hit;
    logic [NUM_WAYS-1:0] valid;
    line_t               rd_line0;
    line_t               rd_line1;
    logic [NUM_WAYS-1:0] wr_en;
    index_t              wr_index;
    tag_t                wr_tag;
    line_t               wr_line;
    logic                clr_en;
    index_t              clr_index;
    index_t              lru_index;
    logic                lru_touch;
    logic                lru_touched_way;
    logic                lru_victim;
    logic                enable;
    logic                inval_pending;
    logic                sweep_done;

    icache_tag_array u_tag_array (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_index  (rd_index),
        .cmp_tag   (cmp_tag),
        .hit       (hit),
        .valid     (valid),
        .wr_en     (wr_en),
        .wr_index  (wr_index),
        .wr_tag    (wr_tag),
        .clr_en    (clr_en),
        .clr_index (clr_index)
    );

    icache_data_array u_data_array (
        .clk      (clk),
        .rd_index (rd_index),
        .rd_line0 (rd_line0),
        .rd_line1 (rd_line1),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_line  (wr_line)
    );

    icache_lru u_lru (
        .clk         (clk),
        .rst_n       (rst_n),
        .index       (lru_index),
        .touch       (lru_touch),
        .touched_way (lru_touched_way),
        .victim      (lru_victim)
    );

    icache_maint_regs u_maint_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_we        (cfg_we),
        .cfg_wdata     (cfg_wdata),
        .sweep_done    (sweep_done),
        .enable        (enable),
        .inval_pending (inval_pending)
    );

    icache_ctrl u_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .fetch_req_valid (fetch_req_valid),
        .fetch_req       (fetch_req),
        .fetch_rsp_valid (fetch_rsp_valid),
        .fetch_rsp       (fetch_rsp),
        .busy            (busy),
        .enable          (enable),
        .inval_pending   (inval_pending),
        .sweep_done      (sweep_done),
        .rd_index        (rd_index),
        .cmp_tag         (cmp_tag),
        .hit             (hit),
        .valid           (valid),
        .rd_line0        (rd_line0),
        .rd_line1        (rd_line1),
        .wr_en           (wr_en),
        .wr_index        (wr_index),
        .wr_tag          (wr_tag),
        .wr_line         (wr_line),
        .clr_en          (clr_en),
        .clr_index       (clr_index),
        .lru_index       (lru_index),
        .lru_touch       (lru_touch),
        .lru_touched_way (lru_touched_way),
        .lru_victim      (lru_victim),
        .mem_req_valid   (mem_req_valid),
        .mem_req         (mem_req),
        .mem_rsp_valid   (mem_rsp_valid),
        .mem_rsp_data    (mem_rsp_data)
    );

endmodule

`default_nettype wire

//--- logic/icache_ctrl.sv
// request buffer, lookup/refill/uncached/sweep FSM, victim choice, word select, response register
`timescale 1ns/1ns
`default_nettype none

module icache_ctrl import icache_pkg::*; (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                fetch_req_valid,
    input  wire fetch_req_t          fetch_req,
    output logic                     fetch_rsp_valid,
    output fetch_rsp_t               fetch_rsp,
    output logic                     busy,
    input  wire logic                enable,
    input  wire logic                inval_pending,
    output logic                     sweep_done,
    output index_t                   rd_index,
    output tag_t                     cmp_tag,
    input  wire logic [NUM_WAYS-1:0] hit,
    input  wire logic [NUM_WAYS-1:0] valid,
    input  wire line_t               rd_line0,
    input  wire line_t               rd_line1,
    output logic [NUM_WAYS-1:0]      wr_en,
    output index_t                   wr_index,
    output tag_t                     wr_tag,
    output line_t                    wr_line,
    output logic                     clr_en,
    output index_t                   clr_index,
    output index_t                   lru_index,
    output logic                     lru_touch,
    output logic                     lru_touched_way,
    input  wire logic                lru_victim,
    output logic                     mem_req_valid,
    output mem_req_t                 mem_req,
    input  wire logic                mem_rsp_valid,
    input  wire line_t               mem_rsp_data
);

    ctrl_state_t state;
    addr_t       req_pc;
    logic        req_cached;
    logic        fill_way;
    index_t      sweep_idx;

    logic        accept;
    logic        hit_any;
    logic        load_hit;
    logic        load_mem;
    logic        fill_done;
    logic        victim_way;
    line_t       src_line;

    // word pair at the offset, odd offsets give one word
    function automatic pair_t select_pair(line_t line, offset_t off);
        word_t lo;
        word_t hi;
        lo = line[off*WORD_W +: WORD_W];
        hi = line[offset_t'({off[1], 1'b1})*WORD_W +: WORD_W];
        if (off[0]) begin
            hi = '0;
        end
        return {hi, lo};
    endfunction

    //////////////////////////////
    // decode
    //////////////////////////////
    assign accept    = (state == idle) && !inval_pending && fetch_req_valid;
    assign hit_any   = |hit;
    assign load_hit  = (state == lookup) && req_cached && hit_any;
    assign load_mem  = ((state == refill) || (state == uncached)) && mem_rsp_valid;
    assign fill_done = (state == refill) && mem_rsp_valid;

    // way 0 if free, then way 1, then the LRU way
    assign victim_way = !valid[0] ? 1'b0 : (!valid[1] ? 1'b1 : lru_victim);

    assign src_line = (state == lookup) ? (hit[1] ? rd_line1 : rd_line0) : mem_rsp_data;

    // array read at the incoming PC while idle, else hold the buffered set
    assign rd_index = (state == idle) ? pc_index(fetch_req.pc) : pc_index(req_pc);
    assign cmp_tag  = pc_tag(req_pc);

    //////////////////////////////
    // FSM
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state           <= idle;
            fetch_rsp_valid <= 1'b0;
            mem_req_valid   <= 1'b0;
            sweep_idx       <= '0;
        end else begin
            fetch_rsp_valid <= 1'b0;
            mem_req_valid   <= 1'b0;
            case (state)
                idle: begin
                    if (inval_pending) begin
                        state     <= sweep;
                        sweep_idx <= '0;
                    end else if (fetch_req_valid) begin
                        state <= lookup;
                    end
                end
                lookup: begin
                    if (!req_cached) begin
                        state         <= uncached;
                        mem_req_valid <= 1'b1;
                    end else if (hit_any) begin
                        state           <= idle;
                        fetch_rsp_valid <= 1'b1;
                    end else begin
                        state         <= refill;
                        mem_req_valid <= 1'b1;
                    end
                end
                refill, uncached: begin
                    if (mem_rsp_valid) begin
                        state           <= idle;
                        fetch_rsp_valid <= 1'b1;
                    end
                end
                sweep: begin
                    sweep_idx <= sweep_idx + 1'b1;
                    if (sweep_done) begin
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // request buffer, enable sampled once per fetch
    always_ff @(posedge clk) begin
        if (accept) begin
            req_pc     <= fetch_req.pc;
            req_cached <= enable;
        end
        if ((state == lookup) && !hit_any) begin
            fill_way <= victim_way;
        end
    end

    // response register
    always_ff @(posedge clk) begin
        if (load_hit || load_mem) begin
            fetch_rsp <= '{
                data:         select_pair(src_line, pc_offset(req_pc)),
                pc:           req_pc,
                second_valid: ~req_pc[BYTE_OFF_W]
            };
        end
    end

    //////////////////////////////
    // array, LRU and memory side
    //////////////////////////////
    assign wr_en    = fill_done ? (fill_way ? 2'b10 : 2'b01) : '0;
    assign wr_index = pc_index(req_pc);
    assign wr_tag   = pc_tag(req_pc);
    assign wr_line  = mem_rsp_data;

    assign clr_en     = (state == sweep);
    assign clr_index  = sweep_idx;
    assign sweep_done = (state == sweep) && (sweep_idx == index_t'(NUM_SETS - 1));

    assign lru_index       = pc_index(req_pc);
    assign lru_touch       = load_hit || fill_done;
    assign lru_touched_way = (state == lookup) ? hit[1] : fill_way;

    assign mem_req = '{addr: line_base(req_pc)};

    // pending invalidate holds off new fetches
    assign busy = (state != idle) || inval_pending;

endmodule

`default_nettype wire

//--- logic/icache_maint_regs.sv
// maintenance registers, cache enable and sticky invalidate-all request
`timescale 1ns/1ns
`default_nettype none

module icache_maint_regs import icache_pkg::*; (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             cfg_we,
    input  wire logic [CFG_W-1:0] cfg_wdata,
    input  wire logic             sweep_done,
    output logic                  enable,
    output logic                  inval_pending
);

    logic inval_req;
    // second request arriving while one is already pending
    logic inval_queued;

    assign inval_req = cfg_we && cfg_wdata[CFG_INVAL_BIT];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enable        <= 1'b1;
            inval_pending <= 1'b0;
            inval_queued  <= 1'b0;
        end else begin
            if (cfg_we) begin
                enable <= cfg_wdata[CFG_ENABLE_BIT];
            end

            if (sweep_done) begin
                // a request during the sweep starts one more
                inval_pending <= inval_queued || inval_req;
                inval_queued  <= 1'b0;
            end else if (inval_req) begin
                if (inval_pending) begin
                    inval_queued <= 1'b1;
                end else begin
                    inval_pending <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/icache_lru.sv
// one-bit-per-set replacement state with touch update and victim output
`timescale 1ns/1ns
`default_nettype none

module icache_lru import icache_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst_n,
    input  wire index_t index,
    input  wire logic   touch,
    input  wire logic   touched_way,
    output logic        victim
);

    // bit names the least recently used way of each set
    logic [NUM_SETS-1:0] lru_bits;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lru_bits <= '0;
        end else if (touch) begin
            lru_bits[index] <= ~touched_way;
        end
    end

    assign victim = lru_bits[index];

endmodule

`default_nettype wire

//--- logic/icache_data_array.sv
// two-way line storage with registered read and whole-line fill write
`timescale 1ns/1ns
`default_nettype none

module icache_data_array import icache_pkg::*; (
    input  wire logic                clk,
    input  wire index_t              rd_index,
    output line_t                    rd_line0,
    output line_t                    rd_line1,
    input  wire logic [NUM_WAYS-1:0] wr_en,
    input  wire index_t              wr_index,
    input  wire line_t               wr_line
);

    line_t line_mem [NUM_WAYS][NUM_SETS];

    // fill writes one whole line into the chosen way
    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (wr_en[w]) begin
                line_mem[w][wr_index] <= wr_line;
            end
        end
    end

    // both ways read every cycle, selection happens in the controller
    always_ff @(posedge clk) begin
        rd_line0 <= line_mem[0][rd_index];
        rd_line1 <= line_mem[1][rd_index];
    end

endmodule

`default_nettype wire

//--- logic/icache_tag_array.sv
// two-way tag and valid storage with registered read, hit compare, fill write and set clear
`timescale 1ns/1ns
`default_nettype none

module icache_tag_array import icache_pkg::*; (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire index_t              rd_index,
    input  wire tag_t                cmp_tag,
    output logic [NUM_WAYS-1:0]      hit,
    output logic [NUM_WAYS-1:0]      valid,
    input  wire logic [NUM_WAYS-1:0] wr_en,
    input  wire index_t              wr_index,
    input  wire tag_t                wr_tag,
    input  wire logic                clr_en,
    input  wire index_t              clr_index
);

    tag_t                              tag_mem [NUM_WAYS][NUM_SETS];
    logic [NUM_WAYS-1:0][NUM_SETS-1:0] valid_bits;
    tag_t                              tag_q [NUM_WAYS];
    logic [NUM_WAYS-1:0]               valid_q;

    // tag storage, written on fill only
    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (wr_en[w]) begin
                tag_mem[w][wr_index] <= wr_tag;
            end
        end
    end

    // valid bits, fill sets and sweep clears both ways of one set
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_bits <= '0;
        end else begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (clr_en) begin
                    valid_bits[w][clr_index] <= 1'b0;
                end
                if (wr_en[w]) begin
                    valid_bits[w][wr_index] <= 1'b1;
                end
            end
        end
    end

    // registered read port
    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            tag_q[w] <= tag_mem[w][rd_index];
        end
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                valid_q[w] <= valid_bits[w][rd_index];
            end
        end
    end

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit[w] = valid_q[w] && (tag_q[w] == cmp_tag);
        end
    end

    assign valid = valid_q;

endmodule

`default_nettype wire

//--- logic/icache_pkg.sv
// icache geometry constants, width types, port structs, controller states, address helpers
`default_nettype none

package icache_pkg;

    //////////////////////////////
    // geometry
    //////////////////////////////
    localparam int ADDR_W         = 32;
    localparam int WORD_W         = 32;
    localparam int BYTE_OFF_W     = 2;
    localparam int OFFSET_W       = 2;
    localparam int INDEX_W        = 4;
    localparam int NUM_SETS       = 1 << INDEX_W;
    localparam int NUM_WAYS       = 2;
    localparam int WORDS_PER_LINE = 1 << OFFSET_W;
    localparam int LINE_W         = WORD_W * WORDS_PER_LINE;
    localparam int LINE_OFF_W     = OFFSET_W + BYTE_OFF_W;
    // tag starts above the word offset, so it overlaps the top index bits
    localparam int TAG_W          = ADDR_W - INDEX_W - OFFSET_W;

    // maintenance register bits
    localparam int CFG_W          = 2;
    localparam int CFG_ENABLE_BIT = 0;
    localparam int CFG_INVAL_BIT  = 1;

    //////////////////////////////
    // types
    //////////////////////////////
    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [2*WORD_W-1:0] pair_t;
    typedef logic [LINE_W-1:0]   line_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-1:0] offset_t;

    typedef struct packed {
        addr_t pc;
    } fetch_req_t;

    typedef struct packed {
        pair_t data;
        addr_t pc;
        logic  second_valid;
    } fetch_rsp_t;

    // line aligned, low LINE_OFF_W bits are zero
    typedef struct packed {
        addr_t addr;
    } mem_req_t;

    typedef enum logic [2:0] {
        idle,
        lookup,
        refill,
        uncached,
        sweep
    } ctrl_state_t;

    //////////////////////////////
    // address fields
    //////////////////////////////
    function automatic index_t pc_index(addr_t pc);
        return pc[LINE_OFF_W +: INDEX_W];
    endfunction

    function automatic offset_t pc_offset(addr_t pc);
        return pc[BYTE_OFF_W +: OFFSET_W];
    endfunction

    function automatic tag_t pc_tag(addr_t pc);
        return pc[ADDR_W-1 -: TAG_W];
    endfunction

    function automatic addr_t line_base(addr_t pc);
        return {pc[ADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};
    endfunction

endpackage

`default_nettype wire
